/* rtl/rv_pkg.sv */
`default_nettype none

package rv_pkg;

    // =====================================================================
    // Widths and constants
    // =====================================================================
    parameter int xlen_p       = 32;    // Data and address width
    parameter int reg_addr_w_p = 5;     // 32 architectural registers

    // addi x0,x0,0 fills a flushed slot
    parameter logic [xlen_p-1:0] nop_inst_p = 32'h0000_0013;

    // Major opcodes in use
    typedef enum logic [6:0] {
        op_reg        = 7'b0110011,
        op_imm        = 7'b0010011,
        op_load       = 7'b0000011,
        op_store      = 7'b0100011,
        op_branch     = 7'b1100011,
        op_jal        = 7'b1101111,
        op_nop_bubble = 7'b0000000     // Invalid slot, no side effects
    } opcode_e;

    // ALU operations
    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_sll,
        alu_srl,
        alu_sra,
        alu_slt,
        alu_sltu
    } alu_op_e;

    // =====================================================================
    // ID/EX register contents
    // =====================================================================
    typedef struct packed {
        logic                    valid;
        logic [xlen_p-1:0]       pc;
        logic [xlen_p-1:0]       rs1_data;
        logic [xlen_p-1:0]       rs2_data;
        logic [reg_addr_w_p-1:0] rs1;
        logic [reg_addr_w_p-1:0] rs2;
        logic [reg_addr_w_p-1:0] rd;
        logic [xlen_p-1:0]       imm;
        alu_op_e                 alu_op;
        logic [2:0]              funct3;     // Branch condition select
        logic                    a_sel_pc;   // Operand A is the PC
        logic                    b_sel_imm;  // Operand B is the immediate
        logic                    is_branch;
        logic                    is_jal;
        logic                    mem_read;
        logic                    mem_write;
        logic                    reg_write;
    } id_ex_t;

endpackage

`default_nettype wire

/* rtl/rv_exmem_if.sv */
`timescale 1ns/1ps
`default_nettype none

// Execute result on its way into the memory stage, no handshake
interface rv_exmem_if import rv_pkg::*; ();

    logic                    valid;
    logic [reg_addr_w_p-1:0] rd;
    logic [xlen_p-1:0]       result;      // ALU result or load/store address
    logic [xlen_p-1:0]       store_data;  // Forwarded rs2
    logic                    mem_read;
    logic                    mem_write;
    logic                    reg_write;

    modport ex  (output valid, rd, result, store_data, mem_read, mem_write, reg_write);
    modport mem (input  valid, rd, result, store_data, mem_read, mem_write, reg_write);

endinterface

`default_nettype wire

/* rtl/rv_fetch.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_fetch import rv_pkg::*; #(
    parameter int imem_depth_p = 64
) (
    input  logic                            clk,
    input  logic                            reset_i,
    input  logic                            imem_we_i,
    input  logic [$clog2(imem_depth_p)-1:0] imem_addr_i,   // Word index
    input  logic [xlen_p-1:0]               imem_data_i,
    input  logic                            redirect_i,
    input  logic [xlen_p-1:0]               redirect_pc_i,
    output logic                            if_valid_o,
    output logic [xlen_p-1:0]               if_pc_o,
    output logic [xlen_p-1:0]               if_inst_o
);

    localparam int imem_aw_lp = $clog2(imem_depth_p);

    logic [xlen_p-1:0] pc_q;
    logic [xlen_p-1:0] imem [imem_depth_p];     // Program storage
    logic [xlen_p-1:0] inst_rd;

    // Program load port, used while the core sits in reset
    always_ff @(posedge clk) begin
        if (imem_we_i) begin
            imem[imem_addr_i] <= imem_data_i;
        end
    end

    assign inst_rd = imem[pc_q[imem_aw_lp+1:2]];  // Async word read

    // =====================================================================
    // PC
    // =====================================================================
    always_ff @(posedge clk) begin
        if (reset_i) begin
            pc_q <= '0;                     // Held at 0 during reset
        end else if (redirect_i) begin
            pc_q <= redirect_pc_i;          // Taken branch or jal from EX
        end else begin
            pc_q <= pc_q + xlen_p'(4);
        end
    end

    // IF/ID register, a redirect kills the slot being fetched
    always_ff @(posedge clk) begin
        if_pc_o <= pc_q;
        if (reset_i || redirect_i) begin
            if_valid_o <= 1'b0;
            if_inst_o  <= nop_inst_p;       // Bubble
        end else begin
            if_valid_o <= 1'b1;
            if_inst_o  <= inst_rd;
        end
    end

endmodule

`default_nettype wire

/* rtl/rv_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_decode import rv_pkg::*; (
    input  logic                    clk,
    input  logic                    reset_i,
    input  logic                    if_valid_i,
    input  logic [xlen_p-1:0]       if_pc_i,
    input  logic [xlen_p-1:0]       if_inst_i,
    input  logic                    redirect_i,
    input  logic                    wb_valid_i,
    input  logic [reg_addr_w_p-1:0] wb_rd_i,
    input  logic [xlen_p-1:0]       wb_data_i,
    output id_ex_t                  id_ex_o
);

    logic [xlen_p-1:0]       regs [2**reg_addr_w_p];
    opcode_e                 opcode;
    logic [2:0]              funct3;
    logic [reg_addr_w_p-1:0] rs1, rs2;
    logic [xlen_p-1:0]       imm_i, imm_s, imm_b, imm_j;
    id_ex_t                  id_ex_d;

    // funct3 plus funct7 bit 5 to ALU operation
    function automatic alu_op_e alu_decode(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  return alt ? alu_sub : alu_add;
            3'b001:  return alu_sll;
            3'b010:  return alu_slt;
            3'b011:  return alu_sltu;
            3'b100:  return alu_xor;
            3'b101:  return alt ? alu_sra : alu_srl;
            3'b110:  return alu_or;
            default: return alu_and;
        endcase
    endfunction

    // Invalid slots decode as bubbles
    assign opcode = if_valid_i ? opcode_e'(if_inst_i[6:0]) : op_nop_bubble;
    assign funct3 = if_inst_i[14:12];
    assign rs1    = if_inst_i[19:15];
    assign rs2    = if_inst_i[24:20];

    // Immediate formats
    assign imm_i = {{20{if_inst_i[31]}}, if_inst_i[31:20]};
    assign imm_s = {{20{if_inst_i[31]}}, if_inst_i[31:25], if_inst_i[11:7]};
    assign imm_b = {{19{if_inst_i[31]}}, if_inst_i[31], if_inst_i[7],
                    if_inst_i[30:25], if_inst_i[11:8], 1'b0};
    assign imm_j = {{11{if_inst_i[31]}}, if_inst_i[31], if_inst_i[19:12],
                    if_inst_i[20], if_inst_i[30:21], 1'b0};

    // =====================================================================
    // Register file
    // =====================================================================
    always_ff @(posedge clk) begin
        if (wb_valid_i) begin
            regs[wb_rd_i] <= wb_data_i;     // wb_valid_i implies rd != 0
        end
    end

    // =====================================================================
    // Control decode
    // =====================================================================
    always_comb begin
        id_ex_d          = '0;
        id_ex_d.valid    = if_valid_i;
        id_ex_d.pc       = if_pc_i;
        id_ex_d.rs1      = rs1;
        id_ex_d.rs2      = rs2;
        id_ex_d.rd       = if_inst_i[11:7];
        id_ex_d.funct3   = funct3;
        id_ex_d.alu_op   = alu_add;
        // Reads see a same-cycle writeback, x0 is always zero
        if (rs1 == '0)                            id_ex_d.rs1_data = '0;
        else if (wb_valid_i && wb_rd_i == rs1)    id_ex_d.rs1_data = wb_data_i;
        else                                      id_ex_d.rs1_data = regs[rs1];
        if (rs2 == '0)                            id_ex_d.rs2_data = '0;
        else if (wb_valid_i && wb_rd_i == rs2)    id_ex_d.rs2_data = wb_data_i;
        else                                      id_ex_d.rs2_data = regs[rs2];
        case (opcode)
            op_reg: begin
                id_ex_d.alu_op    = alu_decode(funct3, if_inst_i[30]);
                id_ex_d.reg_write = 1'b1;
            end
            op_imm: begin
                // Only srai uses bit 30, addi has no subtract form
                id_ex_d.alu_op    = alu_decode(funct3, funct3 == 3'b101 && if_inst_i[30]);
                id_ex_d.imm       = imm_i;
                id_ex_d.b_sel_imm = 1'b1;
                id_ex_d.reg_write = 1'b1;
            end
            op_load: begin
                id_ex_d.imm       = imm_i;      // Address = rs1 + imm
                id_ex_d.b_sel_imm = 1'b1;
                id_ex_d.mem_read  = 1'b1;
                id_ex_d.reg_write = 1'b1;
            end
            op_store: begin
                id_ex_d.imm       = imm_s;
                id_ex_d.b_sel_imm = 1'b1;
                id_ex_d.mem_write = 1'b1;
            end
            op_branch: begin
                id_ex_d.imm       = imm_b;
                id_ex_d.is_branch = 1'b1;
            end
            op_jal: begin
                id_ex_d.imm       = imm_j;
                id_ex_d.is_jal    = 1'b1;
                id_ex_d.a_sel_pc  = 1'b1;       // ALU forms PC+4 for the link
                id_ex_d.reg_write = 1'b1;
            end
            default: ;                          // Bubble or unsupported, no effects
        endcase
    end

    // ID/EX register, controls squashed on reset and on redirect
    always_ff @(posedge clk) begin
        id_ex_o <= id_ex_d;
        if (reset_i || redirect_i) begin
            id_ex_o.valid     <= 1'b0;
            id_ex_o.is_branch <= 1'b0;
            id_ex_o.is_jal    <= 1'b0;
            id_ex_o.mem_read  <= 1'b0;
            id_ex_o.mem_write <= 1'b0;
            id_ex_o.reg_write <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* rtl/rv_execute.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_execute import rv_pkg::*; (
    input  logic                    clk,
    input  logic                    reset_i,
    input  id_ex_t                  id_ex_i,
    input  logic                    wb_valid_i,
    input  logic [reg_addr_w_p-1:0] wb_rd_i,
    input  logic [xlen_p-1:0]       wb_data_i,
    output logic                    redirect_o,
    output logic [xlen_p-1:0]       redirect_pc_o,
    rv_exmem_if.ex                  exmem
);

    logic              fwd_mem_ok;    // EX/MEM holds a usable ALU result
    logic [xlen_p-1:0] rs1_fwd, rs2_fwd;
    logic [xlen_p-1:0] op_a, op_b;
    logic [xlen_p-1:0] alu_res;
    logic              take_branch;

    // =====================================================================
    // Forwarding, newest first
    // =====================================================================
    // Load data is not ready in EX/MEM, it comes via writeback instead
    assign fwd_mem_ok = exmem.valid && exmem.reg_write && !exmem.mem_read
                        && exmem.rd != '0;

    always_comb begin
        if (fwd_mem_ok && exmem.rd == id_ex_i.rs1)       rs1_fwd = exmem.result;
        else if (wb_valid_i && wb_rd_i == id_ex_i.rs1)   rs1_fwd = wb_data_i;
        else                                             rs1_fwd = id_ex_i.rs1_data;
        if (fwd_mem_ok && exmem.rd == id_ex_i.rs2)       rs2_fwd = exmem.result;
        else if (wb_valid_i && wb_rd_i == id_ex_i.rs2)   rs2_fwd = wb_data_i;
        else                                             rs2_fwd = id_ex_i.rs2_data;
    end

    // Operand selects, jal adds 4 to the PC for its link value
    assign op_a = id_ex_i.a_sel_pc ? id_ex_i.pc : rs1_fwd;
    assign op_b = id_ex_i.is_jal    ? xlen_p'(4) :
                  id_ex_i.b_sel_imm ? id_ex_i.imm : rs2_fwd;

    // =====================================================================
    // ALU
    // =====================================================================
    always_comb begin
        case (id_ex_i.alu_op)
            alu_sub:  alu_res = op_a - op_b;
            alu_and:  alu_res = op_a & op_b;
            alu_or:   alu_res = op_a | op_b;
            alu_xor:  alu_res = op_a ^ op_b;
            alu_sll:  alu_res = op_a << op_b[4:0];
            alu_srl:  alu_res = op_a >> op_b[4:0];
            alu_sra:  alu_res = $signed(op_a) >>> op_b[4:0];
            alu_slt:  alu_res = xlen_p'($signed(op_a) < $signed(op_b));
            alu_sltu: alu_res = xlen_p'(op_a < op_b);
            default:  alu_res = op_a + op_b;     // alu_add
        endcase
    end

    // Branch condition on forwarded registers
    always_comb begin
        case (id_ex_i.funct3)
            3'b000:  take_branch = rs1_fwd == rs2_fwd;                  // beq
            3'b001:  take_branch = rs1_fwd != rs2_fwd;                  // bne
            3'b100:  take_branch = $signed(rs1_fwd) < $signed(rs2_fwd); // blt
            3'b101:  take_branch = $signed(rs1_fwd) >= $signed(rs2_fwd);// bge
            3'b110:  take_branch = rs1_fwd < rs2_fwd;                   // bltu
            3'b111:  take_branch = rs1_fwd >= rs2_fwd;                  // bgeu
            default: take_branch = 1'b0;
        endcase
    end

    // Redirect straight from ID/EX, fetch and decode flush on it
    assign redirect_o    = id_ex_i.valid &&
                           (id_ex_i.is_jal || (id_ex_i.is_branch && take_branch));
    assign redirect_pc_o = id_ex_i.pc + id_ex_i.imm;

    // =====================================================================
    // EX/MEM register
    // =====================================================================
    always_ff @(posedge clk) begin
        exmem.rd         <= id_ex_i.rd;
        exmem.result     <= alu_res;
        exmem.store_data <= rs2_fwd;
        if (reset_i) begin
            exmem.valid     <= 1'b0;
            exmem.mem_read  <= 1'b0;
            exmem.mem_write <= 1'b0;
            exmem.reg_write <= 1'b0;
        end else begin
            exmem.valid     <= id_ex_i.valid;
            exmem.mem_read  <= id_ex_i.mem_read;
            exmem.mem_write <= id_ex_i.mem_write;
            exmem.reg_write <= id_ex_i.reg_write;
        end
    end

endmodule

`default_nettype wire

/* rtl/rv_memory.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_memory import rv_pkg::*; #(
    parameter int dmem_depth_p = 64
) (
    input  logic                    clk,
    input  logic                    reset_i,
    rv_exmem_if.mem                 exmem,
    output logic                    wb_valid_o,
    output logic [reg_addr_w_p-1:0] wb_rd_o,
    output logic [xlen_p-1:0]       wb_data_o
);

    localparam int dmem_aw_lp = $clog2(dmem_depth_p);

    logic [xlen_p-1:0]     dmem [dmem_depth_p];
    logic [dmem_aw_lp-1:0] word_addr;
    logic [xlen_p-1:0]     load_data;
    logic                  wb_valid_d;

    assign word_addr = exmem.result[dmem_aw_lp+1:2];   // Word access only

    // Data memory, write on the edge and read through
    always_ff @(posedge clk) begin
        if (exmem.valid && exmem.mem_write) begin
            dmem[word_addr] <= exmem.store_data;
        end
    end
    assign load_data = dmem[word_addr];

    // x0 targets retire silently
    assign wb_valid_d = exmem.valid && exmem.reg_write && exmem.rd != '0;

    // =====================================================================
    // MEM/WB register
    // =====================================================================
    always_ff @(posedge clk) begin
        if (reset_i) begin
            wb_valid_o <= 1'b0;
            wb_rd_o    <= '0;
            wb_data_o  <= '0;
        end else begin
            wb_valid_o <= wb_valid_d;
            if (wb_valid_d) begin                       // Hold last retired value
                wb_rd_o   <= exmem.rd;
                wb_data_o <= exmem.mem_read ? load_data : exmem.result;
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/rv_core.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_core import rv_pkg::*; #(
    parameter int imem_depth_p = 64,
    parameter int dmem_depth_p = 64
) (
    input  logic                            clk,
    input  logic                            reset_i,
    input  logic                            imem_we_i,
    input  logic [$clog2(imem_depth_p)-1:0] imem_addr_i,
    input  logic [xlen_p-1:0]               imem_data_i,
    output logic                            wb_valid_o,
    output logic [reg_addr_w_p-1:0]         wb_rd_o,
    output logic [xlen_p-1:0]               wb_data_o
);

    // IF/ID
    logic              if_valid;
    logic [xlen_p-1:0] if_pc, if_inst;
    // ID/EX
    id_ex_t            id_ex;
    // Flush from execute
    logic              redirect;
    logic [xlen_p-1:0] redirect_pc;

    rv_exmem_if exmem ();

    // =====================================================================
    // Pipeline stages
    // =====================================================================
    rv_fetch #(.imem_depth_p(imem_depth_p)) i_fetch (
        .clk           (clk),
        .reset_i       (reset_i),
        .imem_we_i     (imem_we_i),
        .imem_addr_i   (imem_addr_i),
        .imem_data_i   (imem_data_i),
        .redirect_i    (redirect),
        .redirect_pc_i (redirect_pc),
        .if_valid_o    (if_valid),
        .if_pc_o       (if_pc),
        .if_inst_o     (if_inst)
    );

    rv_decode i_decode (
        .clk        (clk),
        .reset_i    (reset_i),
        .if_valid_i (if_valid),
        .if_pc_i    (if_pc),
        .if_inst_i  (if_inst),
        .redirect_i (redirect),
        .wb_valid_i (wb_valid_o),      // Register file write port
        .wb_rd_i    (wb_rd_o),
        .wb_data_i  (wb_data_o),
        .id_ex_o    (id_ex)
    );

    rv_execute i_execute (
        .clk           (clk),
        .reset_i       (reset_i),
        .id_ex_i       (id_ex),
        .wb_valid_i    (wb_valid_o),   // MEM/WB forwarding path
        .wb_rd_i       (wb_rd_o),
        .wb_data_i     (wb_data_o),
        .redirect_o    (redirect),
        .redirect_pc_o (redirect_pc),
        .exmem         (exmem.ex)
    );

    rv_memory #(.dmem_depth_p(dmem_depth_p)) i_memory (
        .clk        (clk),
        .reset_i    (reset_i),
        .exmem      (exmem.mem),
        .wb_valid_o (wb_valid_o),
        .wb_rd_o    (wb_rd_o),
        .wb_data_o  (wb_data_o)
    );

endmodule

`default_nettype wire

/* verif/rv_core_asserts.sv */
`timescale 1ns/1ps
`default_nettype none

// Checks on the writeback trace port
module rv_core_asserts import rv_pkg::*; (
    input logic                    clk,
    input logic                    reset_i,
    input logic                    wb_valid_i,
    input logic [reg_addr_w_p-1:0] wb_rd_i,
    input logic [xlen_p-1:0]       wb_data_i
);

    // MEM/WB is cleared by the first reset edge
    reset_quiet_a: assert property (@(posedge clk) $past(reset_i) |-> !wb_valid_i)
        else $error("wb_valid_o is high while the core is in reset");

    // x0 targets never reach the trace
    rd_nonzero_a: assert property (@(posedge clk) disable iff (reset_i)
        wb_valid_i |-> wb_rd_i != '0)
        else $error("wb_valid_o is high with wb_rd_o equal to zero");

    outputs_known_a: assert property (@(posedge clk) disable iff (reset_i)
        !$isunknown({wb_valid_i, wb_rd_i, wb_data_i}))
        else $error("A writeback output is unknown after reset");

endmodule

bind rv_core rv_core_asserts i_rv_core_asserts (
    .clk        (clk),
    .reset_i    (reset_i),
    .wb_valid_i (wb_valid_o),
    .wb_rd_i    (wb_rd_o),
    .wb_data_i  (wb_data_o)
);

`default_nettype wire

/* verif/rv_core_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_core_tb import rv_pkg::*; ();

    localparam int imem_depth_lp   = 64;
    localparam int imem_aw_lp      = $clog2(imem_depth_lp);
    localparam int half_period_lp  = 4;      // 8 ns clock
    localparam int reset_cycles_lp = 4;
    localparam int timeout_lp      = 500;    // Cycles allowed for the whole trace
    localparam int quiet_lp        = 20;     // Window for stray writebacks

    logic                    clk;
    logic                    reset;
    logic                    imem_we;
    logic [imem_aw_lp-1:0]   imem_addr;
    logic [xlen_p-1:0]       imem_data;
    logic                    wb_valid;
    logic [reg_addr_w_p-1:0] wb_rd;
    logic [xlen_p-1:0]       wb_data;

    logic [xlen_p-1:0]       prog [$];       // Program words
    logic [reg_addr_w_p-1:0] exp_rd [$];     // Expected trace
    logic [xlen_p-1:0]       exp_data [$];
    int                      wb_idx  = 0;    // Next trace entry
    int                      errors  = 0;
    bit                      data_ok = 1'b0;

    rv_core #(.imem_depth_p(imem_depth_lp), .dmem_depth_p(64)) i_rv_core (
        .clk         (clk),
        .reset_i     (reset),
        .imem_we_i   (imem_we),
        .imem_addr_i (imem_addr),
        .imem_data_i (imem_data),
        .wb_valid_o  (wb_valid),
        .wb_rd_o     (wb_rd),
        .wb_data_o   (wb_data)
    );

    initial begin
        clk = 1'b0;
        forever #(half_period_lp) clk = ~clk;
    end

    // ======================================================================
    // Test data, program section then trace section
    // ======================================================================
    task automatic read_testdata();
        int                fd;
        int                n;
        int                i;
        int                n_inst;
        int                n_exp;
        string             line;
        logic [xlen_p-1:0] v [8];
        logic [xlen_p-1:0] word;
        logic [xlen_p-1:0] vals [$];
        fd = $fopen("verif/rv_core_testdata.hex", "r");
        assert (fd != 0) else begin
            $display("Cannot open verif/rv_core_testdata.hex");
            errors++;
        end
        if (fd != 0) begin
            while ($fgets(line, fd) != 0) begin
                // Scan stops at the first comment character
                n = $sscanf(line, "%h %h %h %h %h %h %h %h",
                            v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7]);
                for (i = 0; i < n; i++) begin
                    vals.push_back(v[i]);
                end
            end
            $fclose(fd);
            n_inst  = (vals.size() > 0) ? int'(vals[0]) : 0;
            n_exp   = (vals.size() > n_inst + 1) ? int'(vals[n_inst + 1]) : 0;
            data_ok = vals.size() > 0 && n_inst <= imem_depth_lp
                      && vals.size() == n_inst + 2 + 2 * n_exp;
            assert (data_ok) else begin
                $display("Test data file has the wrong number of entries");
                errors++;
            end
            if (data_ok) begin
                for (i = 0; i < n_inst; i++) begin
                    prog.push_back(vals[1 + i]);
                end
                for (i = 0; i < n_exp; i++) begin
                    word = vals[n_inst + 2 + 2 * i];
                    exp_rd.push_back(word[reg_addr_w_p-1:0]);
                    exp_data.push_back(vals[n_inst + 3 + 2 * i]);
                end
            end
        end
    endtask

    // One word per clock through the load port, core held in reset
    task automatic load_program();
        int i;
        for (i = 0; i < prog.size(); i++) begin
            @(posedge clk);
            imem_we   <= 1'b1;
            imem_addr <= imem_aw_lp'(i);
            imem_data <= prog[i];
        end
        @(posedge clk);
        imem_we <= 1'b0;
    endtask

    task automatic wait_for_trace();
        int cycles;
        cycles = 0;
        while (wb_idx < exp_rd.size() && cycles < timeout_lp) begin
            @(posedge clk);
            cycles++;
        end
        assert (wb_idx >= exp_rd.size()) else begin
            $display("Timeout: the core stopped retiring after %0d of %0d writebacks",
                     wb_idx, exp_rd.size());
            errors++;
        end
    endtask

    // ======================================================================
    // Trace checker, outputs settled at the falling edge
    // ======================================================================
    always @(negedge clk) begin
        if (!reset && wb_valid) begin
            assert (wb_idx < exp_rd.size()) else begin
                $display("Unexpected writeback to x%0d with data %h", wb_rd, wb_data);
                errors++;
            end
            if (wb_idx < exp_rd.size()) begin
                assert (wb_rd == exp_rd[wb_idx]) else begin
                    $display("Fail wb_rd_o: got %h, expected %h at writeback %0d",
                             wb_rd, exp_rd[wb_idx], wb_idx);
                    errors++;
                end
                assert (wb_data == exp_data[wb_idx]) else begin
                    $display("Fail wb_data_o: got %h, expected %h at writeback %0d",
                             wb_data, exp_data[wb_idx], wb_idx);
                    errors++;
                end
            end
            wb_idx++;
        end
    end

    initial begin
        reset     <= 1'b1;
        imem_we   <= 1'b0;
        imem_addr <= '0;
        imem_data <= '0;
        read_testdata();
        if (data_ok) begin
            load_program();
            repeat (reset_cycles_lp) @(posedge clk);   // Reset tail after the load
            reset <= 1'b0;
            wait_for_trace();
            repeat (quiet_lp) @(posedge clk);          // Anything now is a stray retire
        end
        $display("Writebacks seen: %0d, expected: %0d, errors: %0d",
                 wb_idx, exp_rd.size(), errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* rv_core.f */
rtl/rv_pkg.sv
rtl/rv_exmem_if.sv
rtl/rv_fetch.sv
rtl/rv_decode.sv
rtl/rv_execute.sv
rtl/rv_memory.sv
rtl/rv_core.sv
verif/rv_core_asserts.sv
verif/rv_core_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the rv_core testbench with Verilator and run it
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --timescale 1ns/1ps \
    --top-module rv_core_tb \
    -f rv_core.f \
    -o Vrv_core_tb

./obj_dir/Vrv_core_tb 2>&1 | tee sim.log

if grep -q "TESTBENCH FAILED" sim.log; then
    echo "Simulation failed"
    exit 1
fi
echo "Simulation passed"

/* verif/rv_core_testdata.hex */
# Section 1: instruction count, then instruction words in address order, four per line
# Section 2: writeback count, then pairs of rd and expected data, in retirement order
34                                          # 52 instructions
ff800093 00300113 002081b3 40110233         # 00 addi x1,-8  addi x2,3  add x3  sub x4
0030f2b3 00416333 0021c3b3 00211433         # 10 and x5  or x6  xor x7  sll x8
0020d4b3 4020d533 0020a5b3 0020b633         # 20 srl x9  sra x10  slt x11  sltu x12
0f00f693 10016713 fff0c793 ff90a813         # 30 andi x13  ori x14  xori x15  slti x16
fff13893 00411913 01c0d993 4010da13         # 40 sltiu x17  slli x18  srli x19  srai x20
00510013 00200ab3 00402423 00100b13         # 50 addi x0  add x21,x0,x2  sw x4,8  addi x22
00802b83 00700c13 018b8cb3 01510663         # 60 lw x23,8  addi x24  add x25  beq taken
fff00f93 fff00f93 00209663 fff00f93         # 70 skip skip  bne taken  skip
fff00f93 0020c663 fff00f93 fff00f93         # 80 skip  blt taken  skip skip
00115663 fff00f93 fff00f93 00116663         # 90 bge taken  skip skip  bltu taken
fff00f93 fff00f93 0020f663 fff00f93         # a0 skip skip  bgeu taken  skip
fff00f93 00114663 05500d13 00c00e6f         # b0 skip  blt not taken  addi x26  jal x28
fff00f93 fff00f93 004e0e93 0000006f         # c0 skip skip  addi x29,x28,4  jal x0,0
1c                                          # 28 writebacks
01 fffffff8 02 00000003 03 fffffffb 04 0000000b     # Setup, add, sub
05 fffffff8 06 0000000b 07 fffffff8 08 00000018     # and, or, xor, sll
09 1fffffff 0a ffffffff 0b 00000001 0c 00000000     # srl, sra, slt, sltu
0d 000000f0 0e 00000103 0f 00000007 10 00000001     # andi, ori, xori, slti
11 00000001 12 00000030 13 0000000f 14 fffffffc     # sltiu, slli, srli, srai
15 00000003 16 00000001 17 0000000b 18 00000007     # x0 read, load path
19 00000012 1a 00000055 1c 000000c0 1d 000000c4     # Load forward, branch, jal
